//--- design/fetch_pkg.sv
/* Fetch stage package
   Address widths, TLB and cache geometry, page-table entry fields and FSM encodings */
`default_nettype none

package fetch_pkg;

  // Memory port and instruction widths
  localparam int addr_w = 64;
  localparam int inst_w = 32;

  // 4 KiB pages
  localparam int page_bits = 12;
  localparam int vpn_w = addr_w - page_bits;

  // Direct-mapped TLB, indexed by the low VPN bits
  localparam int tlb_entries = 8;
  localparam int tlb_idx_w = $clog2(tlb_entries);
  localparam int tlb_tag_w = vpn_w - tlb_idx_w;

  // One 64-bit word per line, two instructions each
  localparam int cache_lines = 64;
  localparam int cache_idx_w = $clog2(cache_lines);
  localparam int cache_tag_w = addr_w - 3 - cache_idx_w;

  // PTE layout: valid in bit 0, PPN above the page offset
  localparam int pte_valid_bit = 0;

  typedef enum logic [1:0] {
    idle,
    walk_req,
    walk_wait
  } tlb_state_e;

  typedef enum logic [1:0] {
    lookup,
    fill_req,
    fill_wait
  } cache_state_e;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axi_resp_e;

endpackage

`default_nettype wire

//--- design/mem_rd_if.sv
/* AXI4-Lite read channels (AR and R) between a read master and a read slave */
`timescale 1ns/1ps
`default_nettype none

interface mem_rd_if;
  import fetch_pkg::*;

  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [addr_w-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  modport master (
    output araddr, arvalid, rready,
    input  arready, rdata, rresp, rvalid
  );

  modport slave (
    input  araddr, arvalid, rready,
    output arready, rdata, rresp, rvalid
  );
endinterface

`default_nettype wire

//--- design/itlb.sv
/* Instruction TLB, direct-mapped, one translation stage
   Misses walk a single-level page table at ptbr over an AXI4-Lite read port */
`timescale 1ns/1ps
`default_nettype none

module itlb (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [fetch_pkg::addr_w-1:0] ptbr,
  input  logic                         va_valid,
  input  logic [fetch_pkg::addr_w-1:0] va,
  input  logic                         stall,
  input  logic                         kill,
  output logic                         pa_valid,
  output logic [fetch_pkg::addr_w-1:0] pa,
  output logic                         pa_fault,
  mem_rd_if.master                     mem
);
  import fetch_pkg::*;

  logic [tlb_tag_w-1:0]   tag_q [tlb_entries];
  logic [vpn_w-1:0]       ppn_q [tlb_entries];
  logic [tlb_entries-1:0] ent_valid_q;

  logic              s_valid;
  logic [addr_w-1:0] s_va;
  logic              fault_q;
  logic              discard_q;
  logic              arvalid_q;
  logic [addr_w-1:0] araddr_q;
  tlb_state_e        state;

  logic [vpn_w-1:0]     vpn;
  logic [tlb_idx_w-1:0] idx;
  logic                 hit;
  logic                 r_done;
  logic                 walk_live;
  logic                 fill;

  assign vpn = s_va[addr_w-1:page_bits];
  assign idx = vpn[tlb_idx_w-1:0];
  assign hit = ent_valid_q[idx] && (tag_q[idx] == vpn[vpn_w-1:tlb_idx_w]);

  // Result leaves the stage only when the cache can take it
  assign pa_valid = s_valid && (hit || fault_q) && !stall && !kill;
  assign pa       = {ppn_q[idx], s_va[page_bits-1:0]};
  assign pa_fault = fault_q;

  assign mem.araddr  = araddr_q;
  assign mem.arvalid = arvalid_q;
  assign mem.rready  = (state == walk_wait);

  assign r_done    = (state == walk_wait) && mem.rvalid;
  // A walk whose stage was killed still finishes on the bus, result dropped
  assign walk_live = r_done && !discard_q && !kill;
  assign fill      = walk_live && (mem.rresp == okay) && mem.rdata[pte_valid_bit];

  always_ff @(posedge clk) begin
    if (reset || kill) begin
      s_valid <= 1'b0;
    end else if (va_valid) begin
      s_valid <= 1'b1;
    end else if (pa_valid) begin
      s_valid <= 1'b0;
    end
    if (va_valid) begin
      s_va <= va;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= idle;
      arvalid_q   <= 1'b0;
      fault_q     <= 1'b0;
      discard_q   <= 1'b0;
      ent_valid_q <= '0;
    end else begin
      if (kill || pa_valid) begin
        fault_q <= 1'b0;
      end
      if (state == idle) begin
        discard_q <= 1'b0;
      end else if (kill) begin
        discard_q <= 1'b1;
      end
      case (state)
        idle: begin
          if (s_valid && !hit && !fault_q && !kill) begin
            state     <= walk_req;
            arvalid_q <= 1'b1;
          end
        end
        walk_req: begin
          if (mem.arready) begin
            state     <= walk_wait;
            arvalid_q <= 1'b0;
          end
        end
        walk_wait: begin
          if (r_done) begin
            state <= idle;
            if (fill) begin
              ent_valid_q[idx] <= 1'b1;
            end else if (walk_live) begin
              fault_q <= 1'b1;
            end
          end
        end
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == idle) begin
      araddr_q <= ptbr + addr_w'({vpn, 3'b000});
    end
    if (fill) begin
      tag_q[idx] <= vpn[vpn_w-1:tlb_idx_w];
      ppn_q[idx] <= mem.rdata[addr_w-1:page_bits];
    end
  end

  // The registered AR valid must agree with the walk FSM
  a_no_ar_in_idle: assert property (@(posedge clk) disable iff (reset)
    (state == idle) |-> !mem.arvalid);

endmodule

`default_nettype wire

//--- design/icache.sv
/* Direct-mapped instruction cache with 64-bit lines
   Returns one 32-bit instruction per lookup and refills a line over AXI4-Lite on a miss */
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         pa_valid,
  input  logic [fetch_pkg::addr_w-1:0] pa,
  input  logic                         fault_in,
  input  logic                         stall,
  input  logic                         kill,
  output logic                         data_valid,
  output logic [fetch_pkg::inst_w-1:0] data,
  output logic                         fault_out,
  mem_rd_if.master                     mem
);
  import fetch_pkg::*;

  logic [addr_w-1:0]      line_q [cache_lines];
  logic [cache_tag_w-1:0] ltag_q [cache_lines];
  logic [cache_lines-1:0] line_valid_q;

  logic              c_valid;
  logic [addr_w-1:0] c_pa;
  logic              c_fault;
  logic              discard_q;
  logic              arvalid_q;
  logic [addr_w-1:0] araddr_q;
  cache_state_e      state;

  logic [cache_idx_w-1:0] idx;
  logic [cache_tag_w-1:0] tag;
  logic [addr_w-1:0]      word;
  logic                   hit;
  logic                   r_done;
  logic                   fill_live;
  logic                   fill;

  assign idx  = c_pa[3 +: cache_idx_w];
  assign tag  = c_pa[addr_w-1:3+cache_idx_w];
  assign word = line_q[idx];
  assign hit  = line_valid_q[idx] && (ltag_q[idx] == tag);

  // Faults reply at once, without touching the bus
  assign data_valid = c_valid && (c_fault || hit);
  assign data       = c_pa[2] ? word[addr_w-1:inst_w] : word[inst_w-1:0];
  assign fault_out  = c_fault;

  assign mem.araddr  = araddr_q;
  assign mem.arvalid = arvalid_q;
  assign mem.rready  = (state == fill_wait);

  assign r_done    = (state == fill_wait) && mem.rvalid;
  assign fill_live = r_done && !discard_q && !kill;
  assign fill      = fill_live && (mem.rresp == okay);

  always_ff @(posedge clk) begin
    if (reset || kill) begin
      c_valid <= 1'b0;
      c_fault <= 1'b0;
    end else if (pa_valid) begin
      c_valid <= 1'b1;
      c_fault <= fault_in;
    end else begin
      if (data_valid && !stall) begin
        c_valid <= 1'b0;
      end
      // Bus error on refill
      if (fill_live && !fill) begin
        c_fault <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pa_valid) begin
      c_pa <= pa;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state        <= lookup;
      arvalid_q    <= 1'b0;
      discard_q    <= 1'b0;
      line_valid_q <= '0;
    end else begin
      if (state == lookup) begin
        discard_q <= 1'b0;
      end else if (kill) begin
        discard_q <= 1'b1;
      end
      case (state)
        lookup: begin
          if (c_valid && !c_fault && !hit && !kill) begin
            state     <= fill_req;
            arvalid_q <= 1'b1;
          end
        end
        fill_req: begin
          if (mem.arready) begin
            state     <= fill_wait;
            arvalid_q <= 1'b0;
          end
        end
        fill_wait: begin
          if (r_done) begin
            state <= lookup;
            if (fill) begin
              line_valid_q[idx] <= 1'b1;
            end
          end
        end
        default: state <= lookup;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    // Aligned word address for the refill
    if (state == lookup) begin
      araddr_q <= {c_pa[addr_w-1:3], 3'b000};
    end
    if (fill) begin
      line_q[idx] <= mem.rdata;
      ltag_q[idx] <= tag;
    end
  end

endmodule

`default_nettype wire

//--- design/mem_rd_arbiter.sv
/* Fixed-priority read arbiter, TLB before cache
   Locks the owner until its read data returns and steers R back to it */
`timescale 1ns/1ps
`default_nettype none

module mem_rd_arbiter (
  input  logic     clk,
  input  logic     reset,
  mem_rd_if.slave  tlb,
  mem_rd_if.slave  cache,
  mem_rd_if.master mem
);

  logic lock_q;
  logic addr_done_q;
  // 0 selects the TLB, 1 the cache
  logic owner_q;
  logic sel;

  // Lock as soon as AR is presented so its payload cannot switch under it
  assign sel = lock_q ? owner_q : !tlb.arvalid;

  assign mem.araddr  = sel ? cache.araddr : tlb.araddr;
  assign mem.arvalid = !addr_done_q && (sel ? cache.arvalid : tlb.arvalid);
  assign mem.rready  = addr_done_q && (owner_q ? cache.rready : tlb.rready);

  assign tlb.arready   = !addr_done_q && !sel && mem.arready;
  assign cache.arready = !addr_done_q && sel && mem.arready;

  assign tlb.rvalid   = addr_done_q && !owner_q && mem.rvalid;
  assign cache.rvalid = addr_done_q && owner_q && mem.rvalid;
  assign tlb.rdata    = mem.rdata;
  assign cache.rdata  = mem.rdata;
  assign tlb.rresp    = mem.rresp;
  assign cache.rresp  = mem.rresp;

  always_ff @(posedge clk) begin
    if (reset) begin
      lock_q      <= 1'b0;
      addr_done_q <= 1'b0;
      owner_q     <= 1'b0;
    end else begin
      if (!lock_q && mem.arvalid) begin
        lock_q  <= 1'b1;
        owner_q <= sel;
      end
      if (mem.arvalid && mem.arready) begin
        addr_done_q <= 1'b1;
      end
      if (mem.rvalid && mem.rready) begin
        lock_q      <= 1'b0;
        addr_done_q <= 1'b0;
      end
    end
  end

  a_owner_held: assert property (@(posedge clk) disable iff (reset)
    (addr_done_q && !(mem.rvalid && mem.rready)) |=> (addr_done_q && $stable(owner_q)));

endmodule

`default_nettype wire

//--- design/fetch_unit.sv
/* Fetch unit: PC select, TLB and cache stages, arbiter and the decode output register
   Sustains one instruction per cycle on hits and drops in-flight work on redirect */
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [fetch_pkg::addr_w-1:0] boot_pc,
  input  logic [fetch_pkg::addr_w-1:0] ptbr,
  input  logic                         redirect_valid,
  input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
  input  logic                         flush_valid,
  input  logic [fetch_pkg::addr_w-1:0] flush_pc,
  output logic                         inst_valid,
  input  logic                         inst_ready,
  output logic [fetch_pkg::inst_w-1:0] inst,
  output logic [fetch_pkg::addr_w-1:0] inst_pc_next,
  output logic                         inst_fault,
  mem_rd_if.master                     mem
);
  import fetch_pkg::*;

  mem_rd_if tlb_bus ();
  mem_rd_if cache_bus ();

  logic [addr_w-1:0] pc;
  logic              running;
  logic              s1_valid;
  logic [addr_w-1:0] s1_pc;
  logic              s2_valid;
  logic [addr_w-1:0] s2_pc;

  logic              kill;
  logic [addr_w-1:0] target;
  logic              out_free;
  logic              s2_adv;
  logic              s2_free;
  logic              cache_fault_adv;
  logic              fault_stop;
  logic              tlb_kill;
  logic              tlb_stall;
  logic              issue;

  logic              pa_valid;
  logic [addr_w-1:0] pa;
  logic              pa_fault;
  logic              data_valid;
  logic [inst_w-1:0] data;
  logic              data_fault;

  // Flush beats redirect
  assign kill   = flush_valid || redirect_valid;
  assign target = flush_valid ? flush_pc : redirect_pc;

  assign out_free        = !inst_valid || inst_ready;
  assign s2_adv          = s2_valid && data_valid && out_free;
  assign s2_free         = !s2_valid || s2_adv;
  assign cache_fault_adv = s2_adv && data_fault;
  // A fault leaving either stage ends fetch until the next redirect
  assign fault_stop = (pa_valid && pa_fault) || cache_fault_adv;
  assign tlb_kill   = kill || cache_fault_adv;
  assign tlb_stall  = !s2_free || cache_fault_adv;
  assign issue      = running && (!s1_valid || pa_valid) && !fault_stop && !kill;

  itlb u_itlb (
    .clk(clk), .reset(reset), .ptbr(ptbr),
    .va_valid(issue), .va(pc), .stall(tlb_stall), .kill(tlb_kill),
    .pa_valid(pa_valid), .pa(pa), .pa_fault(pa_fault), .mem(tlb_bus)
  );

  icache u_icache (
    .clk(clk), .reset(reset),
    .pa_valid(pa_valid), .pa(pa), .fault_in(pa_fault), .stall(!out_free), .kill(kill),
    .data_valid(data_valid), .data(data), .fault_out(data_fault), .mem(cache_bus)
  );

  mem_rd_arbiter u_arbiter (
    .clk(clk), .reset(reset), .tlb(tlb_bus), .cache(cache_bus), .mem(mem)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= boot_pc;
      running  <= 1'b1;
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (kill) begin
        pc      <= target;
        running <= 1'b1;
      end else if (issue) begin
        pc <= pc + addr_w'(4);
      end else if (fault_stop) begin
        running <= 1'b0;
      end
      // PC tags mirror the TLB and cache stage occupancy
      if (tlb_kill) begin
        s1_valid <= 1'b0;
      end else if (issue) begin
        s1_valid <= 1'b1;
      end else if (pa_valid) begin
        s1_valid <= 1'b0;
      end
      if (kill) begin
        s2_valid <= 1'b0;
      end else if (pa_valid) begin
        s2_valid <= 1'b1;
      end else if (s2_adv) begin
        s2_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      s1_pc <= pc;
    end
    if (pa_valid) begin
      s2_pc <= s1_pc;
    end
  end

  // Decode-side output register
  always_ff @(posedge clk) begin
    if (reset || kill) begin
      inst_valid <= 1'b0;
    end else if (out_free) begin
      inst_valid <= s2_adv;
    end
    if (s2_adv) begin
      inst         <= data;
      inst_pc_next <= s2_pc + addr_w'(4);
      inst_fault   <= data_fault;
    end
  end

  a_hold_under_backpressure: assert property (@(posedge clk) disable iff (reset)
    (inst_valid && !inst_ready && !flush_valid && !redirect_valid) |=>
      (inst_valid && $stable(inst) && $stable(inst_pc_next) && $stable(inst_fault)));

endmodule

`default_nettype wire

//--- design/fetch_top.sv
/* Fetch stage top level
   Exposes the fetch unit with plain decode, redirect and AXI4-Lite read ports */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic [fetch_pkg::addr_w-1:0] boot_pc,
  input  logic [fetch_pkg::addr_w-1:0] ptbr,
  input  logic                         redirect_valid,
  input  logic [fetch_pkg::addr_w-1:0] redirect_pc,
  input  logic                         flush_valid,
  input  logic [fetch_pkg::addr_w-1:0] flush_pc,
  output logic                         inst_valid,
  input  logic                         inst_ready,
  output logic [fetch_pkg::inst_w-1:0] inst,
  output logic [fetch_pkg::addr_w-1:0] inst_pc_next,
  output logic                         inst_fault,
  output logic [fetch_pkg::addr_w-1:0] m_axi_araddr,
  output logic                         m_axi_arvalid,
  input  logic                         m_axi_arready,
  input  logic [fetch_pkg::addr_w-1:0] m_axi_rdata,
  input  logic [1:0]                   m_axi_rresp,
  input  logic                         m_axi_rvalid,
  output logic                         m_axi_rready
);

  mem_rd_if m_bus ();

  assign m_axi_araddr  = m_bus.araddr;
  assign m_axi_arvalid = m_bus.arvalid;
  assign m_axi_rready  = m_bus.rready;
  assign m_bus.arready = m_axi_arready;
  assign m_bus.rdata   = m_axi_rdata;
  assign m_bus.rresp   = m_axi_rresp;
  assign m_bus.rvalid  = m_axi_rvalid;

  fetch_unit u_fetch_unit (
    .clk            (clk),
    .reset          (reset),
    .boot_pc        (boot_pc),
    .ptbr           (ptbr),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .flush_valid    (flush_valid),
    .flush_pc       (flush_pc),
    .inst_valid     (inst_valid),
    .inst_ready     (inst_ready),
    .inst           (inst),
    .inst_pc_next   (inst_pc_next),
    .inst_fault     (inst_fault),
    .mem            (m_bus)
  );

endmodule

`default_nettype wire

//--- testbench/axi_rd_mem_model.sv
/* AXI4-Lite read-only memory model with random ready and response delays
   Serves a single-level page table at ptbr and a program whose words hash their own VA */
`timescale 1ns/1ps
`default_nettype none

module axi_rd_mem_model #(
  parameter logic [51:0] bad_vpn = 52'h13
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [63:0] ptbr,
  input  logic [63:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [63:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  // Virtual page n lives in physical page n ^ ppn_xor
  localparam logic [51:0] ppn_xor = 52'h45;

  logic        reset_s;
  logic        ar_hs;
  logic        r_hs;
  logic        busy;
  logic        pend;
  logic [63:0] ar_addr;
  logic [63:0] addr_q;
  int unsigned delay;

  function automatic logic [31:0] inst_hash(input logic [63:0] va);
    logic [31:0] x;
    x = va[31:0] ^ 32'h5bd1e995;
    x = x * 32'h9e3779b1;
    return x ^ (x >> 15);
  endfunction

  function automatic logic [63:0] read_word(input logic [63:0] pa, input logic [63:0] root);
    logic [51:0] vpn;
    logic [63:0] va;
    if (pa[63:12] == root[63:12]) begin
      // Page-table entry, indexed by VPN
      vpn = {43'b0, pa[11:3]};
      if (vpn == bad_vpn) return 64'h0;
      return {vpn ^ ppn_xor, 12'h001};
    end
    va = {pa[63:12] ^ ppn_xor, pa[11:3], 3'b000};
    return {inst_hash(va + 64'd4), inst_hash(va)};
  endfunction

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rresp   = 2'b00;
    busy    = 1'b0;
    pend    = 1'b0;
    delay   = 0;
    forever begin
      @(posedge clk);
      reset_s = reset;
      ar_hs   = arvalid && arready;
      r_hs    = rvalid && rready;
      ar_addr = araddr;
      #1;
      if (reset_s) begin
        busy    = 1'b0;
        pend    = 1'b0;
        arready = 1'b0;
        rvalid  = 1'b0;
      end else begin
        if (r_hs) begin
          rvalid = 1'b0;
          busy   = 1'b0;
        end
        if (ar_hs) begin
          busy   = 1'b1;
          pend   = 1'b1;
          addr_q = ar_addr;
          delay  = $urandom % 4;
        end else if (pend) begin
          if (delay == 0) begin
            pend   = 1'b0;
            rvalid = 1'b1;
            rdata  = read_word(addr_q, ptbr);
            rresp  = 2'b00;
          end else begin
            delay = delay - 1;
          end
        end
        // One read at a time and AR ready stalls at random
        arready = !busy && (($urandom % 4) != 0);
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_fetch_top.sv
/* Testbench for the fetch stage
   Drives redirects, flushes and decode back-pressure and checks fetched words against a PC queue */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;
  import fetch_pkg::*;

  localparam logic [63:0] ptbr_addr = 64'h0010_0000;
  localparam logic [63:0] boot_addr = 64'h0001_0f80;
  localparam logic [51:0] bad_vpn   = 52'h13;
  // Whole sequence needs a few thousand cycles even with slow memory
  localparam int timeout_cycles = 20000;

  logic              clk;
  logic              reset;
  logic [addr_w-1:0] boot_pc;
  logic [addr_w-1:0] ptbr;
  logic              redirect_valid;
  logic [addr_w-1:0] redirect_pc;
  logic              flush_valid;
  logic [addr_w-1:0] flush_pc;
  logic              inst_valid;
  logic              inst_ready;
  logic [inst_w-1:0] inst;
  logic [addr_w-1:0] inst_pc_next;
  logic              inst_fault;
  logic [addr_w-1:0] m_axi_araddr;
  logic              m_axi_arvalid;
  logic              m_axi_arready;
  logic [addr_w-1:0] m_axi_rdata;
  logic [1:0]        m_axi_rresp;
  logic              m_axi_rvalid;
  logic              m_axi_rready;

  logic [addr_w-1:0] exp_q [$];
  logic [addr_w-1:0] exp_pc;
  logic              fault_seen = 1'b0;
  int                errors = 0;
  int                accepts = 0;
  int                outstanding = 0;
  int                cycles;
  string             test_name = "reset";

  // Previous-cycle copies for the hold checks
  logic              dec_hold_q = 1'b0;
  logic              ar_hold_q = 1'b0;
  logic [inst_w-1:0] inst_q;
  logic [addr_w-1:0] pc_next_q;
  logic              fault_q;
  logic [addr_w-1:0] araddr_q;

  fetch_top u_dut (
    .clk(clk), .reset(reset), .boot_pc(boot_pc), .ptbr(ptbr),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .flush_valid(flush_valid), .flush_pc(flush_pc),
    .inst_valid(inst_valid), .inst_ready(inst_ready), .inst(inst),
    .inst_pc_next(inst_pc_next), .inst_fault(inst_fault),
    .m_axi_araddr(m_axi_araddr), .m_axi_arvalid(m_axi_arvalid), .m_axi_arready(m_axi_arready),
    .m_axi_rdata(m_axi_rdata), .m_axi_rresp(m_axi_rresp), .m_axi_rvalid(m_axi_rvalid),
    .m_axi_rready(m_axi_rready)
  );

  axi_rd_mem_model #(.bad_vpn(bad_vpn)) u_mem (
    .clk(clk), .reset(reset), .ptbr(ptbr),
    .araddr(m_axi_araddr), .arvalid(m_axi_arvalid), .arready(m_axi_arready),
    .rdata(m_axi_rdata), .rresp(m_axi_rresp), .rvalid(m_axi_rvalid), .rready(m_axi_rready)
  );

  function automatic logic [31:0] inst_hash(input logic [63:0] va);
    logic [31:0] x;
    x = va[31:0] ^ 32'h5bd1e995;
    x = x * 32'h9e3779b1;
    return x ^ (x >> 15);
  endfunction

  task automatic check_value(input string field, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected == actual) else begin
      errors++;
      $display("[FAIL] %s: %s expected %h, got %h", test_name, field, expected, actual);
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #1;
    inst_ready = ($urandom % 4) != 0;
  endtask

  task automatic wait_accepts(input int n);
    int target;
    target = accepts + n;
    while (accepts < target) step_cycle();
  endtask

  // Decode is held off during the redirect cycle so nothing is accepted in it
  task automatic send_redirect(input logic use_redirect, input logic [63:0] rpc,
                               input logic use_flush, input logic [63:0] fpc);
    @(posedge clk);
    #1;
    inst_ready     = 1'b0;
    redirect_valid = use_redirect;
    redirect_pc    = rpc;
    flush_valid    = use_flush;
    flush_pc       = fpc;
    @(posedge clk);
    #1;
    redirect_valid = 1'b0;
    flush_valid    = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reference model of the fetch order
  always @(posedge clk) begin
    if (reset) begin
      exp_q.delete();
      exp_q.push_back(boot_pc);
      fault_seen = 1'b0;
    end else if (redirect_valid || flush_valid) begin
      exp_q.delete();
      exp_q.push_back(flush_valid ? flush_pc : redirect_pc);
      fault_seen = 1'b0;
    end else if (inst_valid && inst_ready) begin
      accepts++;
      assert (!fault_seen) else begin
        errors++;
        $display("error in %s: instruction accepted after a page fault", test_name);
      end
      exp_pc = exp_q.pop_front();
      exp_q.push_back(exp_pc + 64'd4);
      check_value("inst_pc_next", exp_pc + 64'd4, inst_pc_next);
      if (exp_pc[63:12] == bad_vpn) begin
        check_value("inst_fault", 64'd1, 64'(inst_fault));
        fault_seen = 1'b1;
      end else begin
        check_value("inst_fault", 64'd0, 64'(inst_fault));
        check_value("inst", 64'(inst_hash(exp_pc)), 64'(inst));
      end
    end
  end

  // Decode hold and AXI4-Lite read rules
  always @(posedge clk) begin
    if (reset) begin
      outstanding = 0;
    end else begin
      if (dec_hold_q) begin
        check_value("held inst_valid", 64'd1, 64'(inst_valid));
        check_value("held inst", 64'(inst_q), 64'(inst));
        check_value("held inst_pc_next", pc_next_q, inst_pc_next);
        check_value("held inst_fault", 64'(fault_q), 64'(inst_fault));
      end
      if (ar_hold_q) begin
        check_value("held arvalid", 64'd1, 64'(m_axi_arvalid));
        check_value("held araddr", araddr_q, m_axi_araddr);
      end
      if (m_axi_arvalid) begin
        assert (outstanding == 0) else begin
          errors++;
          $display("error in %s: second read requested while one is outstanding", test_name);
        end
      end
      if (m_axi_arvalid && m_axi_arready) begin
        outstanding++;
      end
      if (m_axi_rvalid && m_axi_rready) begin
        outstanding--;
      end
    end
    dec_hold_q = !reset && inst_valid && !inst_ready && !redirect_valid && !flush_valid;
    inst_q     = inst;
    pc_next_q  = inst_pc_next;
    fault_q    = inst_fault;
    ar_hold_q  = !reset && m_axi_arvalid && !m_axi_arready;
    araddr_q   = m_axi_araddr;
  end

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout in %s: run stopped after %0d cycles, errors: %0d", test_name, cycles, errors);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    int unsigned seed_ret;
    seed_ret       = $urandom(32'h047aae5c);
    reset          = 1'b1;
    boot_pc        = boot_addr;
    ptbr           = ptbr_addr;
    inst_ready     = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    flush_valid    = 1'b0;
    flush_pc       = '0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    // Crosses into the next page but leaves the boot lines in the cache
    test_name = "sequential";
    wait_accepts(120);
    test_name = "redirect";
    send_redirect(1'b1, boot_addr, 1'b0, '0);
    wait_accepts(40);
    test_name = "flush priority";
    send_redirect(1'b1, 64'h0001_1800, 1'b1, 64'h0001_2000);
    wait_accepts(40);
    test_name = "page fault";
    send_redirect(1'b1, 64'h0001_2ff0, 1'b0, '0);
    while (!fault_seen) step_cycle();
    // Fetch stays quiet until the next redirect
    repeat (40) step_cycle();
    test_name = "resume";
    send_redirect(1'b1, 64'h0001_0100, 1'b0, '0);
    wait_accepts(30);

    $display("errors: %0d, accepted instructions: %0d", errors, accepts);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
design/fetch_pkg.sv
design/mem_rd_if.sv
design/itlb.sv
design/icache.sv
design/mem_rd_arbiter.sv
design/fetch_unit.sv
design/fetch_top.sv
testbench/axi_rd_mem_model.sv
testbench/tb_fetch_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = tb_fetch_top
RTL_TOP   = fetch_top
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
